/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_tpu_host_link
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* act_loader.sv */
module act_loader (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   go,
    input  tpu_link_pkg::payload_t payload,
    output tpu_link_pkg::act_cmd_t act,
    output logic                   done
);

    logic phase;

    // Payload is row major, the array takes one column per beat
    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= 1'b0;
            act.valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            act.valid <= go || phase;
            done      <= phase;
            phase     <= go;
            if (go) begin
                act.data <= {payload[23:16], payload[7:0]};
            end else if (phase) begin
                act.data <= {payload[31:24], payload[15:8]};
            end
        end
    end

endmodule

/* host_cmd_ctrl.sv */
module host_cmd_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  tpu_link_pkg::byte_t         rx_data,
    input  logic                        rx_valid,
    input  tpu_link_pkg::mlp_status_t   mlp_status,
    input  logic                        wl_done,
    input  logic                        al_done,
    input  logic                        resp_busy,
    output logic                        wl_go,
    output logic                        al_go,
    output tpu_link_pkg::payload_t      payload,
    output tpu_link_pkg::resp_load_t    resp,
    output logic                        start_mlp,
    output logic                        weights_ready
);

    typedef enum logic [2:0] {
        IDLE,
        RECV_PAYLOAD,
        LOAD_WEIGHTS,
        LOAD_ACTS,
        RESPOND
    } ctrl_state_t;

    ctrl_state_t         state;
    tpu_link_pkg::byte_t opcode;
    logic [1:0]          byte_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            opcode        <= '0;
            byte_cnt      <= '0;
            wl_go         <= 1'b0;
            al_go         <= 1'b0;
            resp          <= '0;
            start_mlp     <= 1'b0;
            weights_ready <= 1'b0;
        end else begin
            wl_go     <= 1'b0;
            al_go     <= 1'b0;
            resp.load <= 1'b0;

            // Engine leaving idle is the start acknowledge
            if (start_mlp && mlp_status.state != tpu_link_pkg::MLP_IDLE) begin
                start_mlp     <= 1'b0;
                weights_ready <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (rx_valid) begin
                        opcode   <= rx_data;
                        byte_cnt <= '0;
                        case (rx_data)
                            tpu_link_pkg::OP_WRITE_WEIGHT,
                            tpu_link_pkg::OP_WRITE_ACT: state <= RECV_PAYLOAD;
                            tpu_link_pkg::OP_EXECUTE: start_mlp <= 1'b1;
                            tpu_link_pkg::OP_READ_ACC0: begin
                                resp  <= {1'b1, 1'b1, mlp_status.acc0};
                                state <= RESPOND;
                            end
                            tpu_link_pkg::OP_READ_ACC1: begin
                                resp  <= {1'b1, 1'b1, mlp_status.acc1};
                                state <= RESPOND;
                            end
                            tpu_link_pkg::OP_STATUS: begin
                                resp  <= {1'b1, 1'b0, 24'd0, mlp_status.state,
                                          mlp_status.cycle_cnt[3:0]};
                                state <= RESPOND;
                            end
                            default: ;
                        endcase
                    end
                end
                RECV_PAYLOAD: begin
                    if (rx_valid) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd3) begin
                            if (opcode == tpu_link_pkg::OP_WRITE_WEIGHT) begin
                                wl_go <= 1'b1;
                                state <= LOAD_WEIGHTS;
                            end else begin
                                al_go <= 1'b1;
                                state <= LOAD_ACTS;
                            end
                        end
                    end
                end
                LOAD_WEIGHTS: begin
                    if (wl_done) begin
                        weights_ready <= 1'b1;
                        state         <= IDLE;
                    end
                end
                LOAD_ACTS: begin
                    if (al_done) begin
                        state <= IDLE;
                    end
                end
                RESPOND: begin
                    // busy only rises the cycle after load
                    if (!resp.load && !resp_busy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload byte 0 lands in the lowest position
    always_ff @(posedge clk) begin
        if (state == RECV_PAYLOAD && rx_valid) begin
            payload[{byte_cnt, 3'b000} +: 8] <= rx_data;
        end
    end

    a_one_loader: assert property (@(posedge clk) disable iff (rst)
        !(wl_go && al_go));

endmodule

/* list.f */
tpu_link_pkg.sv
uart_rx.sv
uart_tx.sv
host_cmd_ctrl.sv
weight_loader.sv
act_loader.sv
resp_serializer.sv
tpu_host_link.sv
tb_tpu_host_link.sv

/* resp_serializer.sv */
module resp_serializer (
    input  logic                     clk,
    input  logic                     rst,
    input  tpu_link_pkg::resp_load_t resp,
    input  logic                     tx_ready,
    output tpu_link_pkg::byte_t      tx_data,
    output logic                     tx_valid,
    output logic                     busy
);

    tpu_link_pkg::payload_t resp_buf;
    logic [1:0]             idx;
    logic [1:0]             last_idx;

    assign tx_data = resp_buf[{idx, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            idx      <= '0;
            last_idx <= '0;
            tx_valid <= 1'b0;
            busy     <= 1'b0;
        end else if (resp.load) begin
            idx      <= '0;
            last_idx <= resp.four_bytes ? 2'd3 : 2'd0;
            tx_valid <= 1'b1;
            busy     <= 1'b1;
        end else if (tx_valid && tx_ready) begin
            if (idx == last_idx) begin
                tx_valid <= 1'b0;
            end else begin
                idx <= idx + 2'd1;
            end
        end else if (busy && !tx_valid && tx_ready) begin
            // Last frame has left the wire
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp.load) begin
            resp_buf <= resp.data;
        end
    end

    a_hold_data: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

/* tb_tpu_host_link.sv */
module tb_tpu_host_link;

    localparam int BIT_CLKS   = 8;
    localparam int CLK_PERIOD = 4;
    // Weight 5, act 5, execute 1, two reads 1 each, unknown 1, status 1
    localparam int BYTES_SENT = 15;
    localparam int BYTES_RECV = 9;
    localparam int WATCHDOG_TIME =
        2 * (BYTES_SENT + BYTES_RECV) * 10 * BIT_CLKS * CLK_PERIOD + 2000;

    logic                      clk;
    logic                      rst;
    logic                      uart_rx_line;
    tpu_link_pkg::mlp_status_t mlp_status;
    logic                      uart_tx_line;
    tpu_link_pkg::wf_cmd_t     wf;
    tpu_link_pkg::act_cmd_t    act;
    logic                      start_mlp;
    logic                      weights_ready;

    // Each weight event is {kind, data}: kind 0 reset, 1 col0, 2 col1
    logic [9:0]                    wf_log[$];
    tpu_link_pkg::act_pair_t       act_log[$];
    logic [31:0]                   acc0_val;
    logic [31:0]                   acc1_val;
    tpu_link_pkg::cycle_cnt_t      cnt_val;

    tpu_host_link #(.CLOCK_FREQ(800), .BAUD_RATE(100)) DUT (
        .clk(clk), .rst(rst), .uart_rx_line(uart_rx_line), .mlp_status(mlp_status),
        .uart_tx_line(uart_tx_line), .wf(wf), .act(act), .start_mlp(start_mlp),
        .weights_ready(weights_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (wf.reset) begin
            wf_log.push_back(10'h000);
        end
        if (wf.push_col0) begin
            wf_log.push_back({2'd1, wf.data});
        end
        if (wf.push_col1) begin
            wf_log.push_back({2'd2, wf.data});
        end
        if (act.valid) begin
            act_log.push_back(act.data);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
        $display("TEST FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "check failed");
    endtask

    // 8N1 frame, one bit every BIT_CLKS cycles
    task automatic send_byte(input tpu_link_pkg::byte_t b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx_line <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic recv_byte(output tpu_link_pkg::byte_t b);
        int wait_cnt;
        int i;
        wait_cnt = 0;
        while (uart_tx_line) begin
            @(posedge clk);
            wait_cnt++;
            assert (wait_cnt < 4 * 10 * BIT_CLKS) else report_error("no start bit from DUT");
        end
        // Move to the middle of the start bit
        repeat (BIT_CLKS / 2) @(posedge clk);
        assert (uart_tx_line == 1'b0) else report_error("start bit ended too early");
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(posedge clk);
            b[i] = uart_tx_line;
        end
        repeat (BIT_CLKS) @(posedge clk);
        assert (uart_tx_line == 1'b1) else report_error("stop bit missing");
    endtask

    task automatic check_reset_state();
        assert (uart_tx_line == 1'b1)
            else report_mismatch("uart_tx_line", 32'd1, 32'(uart_tx_line));
        repeat (20) begin
            @(posedge clk);
            assert (start_mlp == 1'b0) else report_mismatch("start_mlp", 32'd0, 32'(start_mlp));
            assert (weights_ready == 1'b0)
                else report_mismatch("weights_ready", 32'd0, 32'(weights_ready));
            assert (wf == '0) else report_mismatch("wf", 32'd0, 32'(wf));
            assert (act.valid == 1'b0) else report_mismatch("act.valid", 32'd0, 32'(act.valid));
        end
    endtask

    task automatic run_write_weight();
        tpu_link_pkg::payload_t pl;
        logic [9:0]             exp[5];
        int                     i;
        pl = $urandom;
        exp[0] = 10'h000;
        exp[1] = {2'd1, pl[7:0]};
        exp[2] = {2'd2, pl[15:8]};
        exp[3] = {2'd1, pl[23:16]};
        exp[4] = {2'd2, pl[31:24]};
        wf_log.delete();
        send_byte(tpu_link_pkg::OP_WRITE_WEIGHT);
        for (i = 0; i < 4; i++) begin
            send_byte(pl[8*i +: 8]);
        end
        i = 0;
        while (!weights_ready && i < 100) begin
            @(posedge clk);
            i++;
        end
        assert (weights_ready) else report_error("weights_ready never rose");
        repeat (4) @(posedge clk);
        assert (wf_log.size() == 5) else report_mismatch("wf event count", 32'd5, wf_log.size());
        for (i = 0; i < 5; i++) begin
            assert (wf_log[i] == exp[i])
                else report_mismatch("wf event", 32'(exp[i]), 32'(wf_log[i]));
        end
    endtask

    task automatic run_write_act();
        tpu_link_pkg::byte_t     b[4];
        tpu_link_pkg::act_pair_t exp0;
        tpu_link_pkg::act_pair_t exp1;
        int                      i;
        for (i = 0; i < 4; i++) begin
            b[i] = 8'($urandom);
        end
        // Column 0 first, row 1 in the high byte
        exp0 = {b[2], b[0]};
        exp1 = {b[3], b[1]};
        act_log.delete();
        send_byte(tpu_link_pkg::OP_WRITE_ACT);
        for (i = 0; i < 4; i++) begin
            send_byte(b[i]);
        end
        i = 0;
        while (act_log.size() < 2 && i < 100) begin
            @(posedge clk);
            i++;
        end
        // Extra cycles catch any stray third beat
        repeat (10) @(posedge clk);
        assert (act_log.size() == 2)
            else report_mismatch("act beat count", 32'd2, act_log.size());
        assert (act_log[0] == exp0)
            else report_mismatch("act.data beat 0", 32'(exp0), 32'(act_log[0]));
        assert (act_log[1] == exp1)
            else report_mismatch("act.data beat 1", 32'(exp1), 32'(act_log[1]));
    endtask

    // Engine model acknowledges the start after 1 to 5 idle cycles
    task automatic run_execute();
        int delay;
        int i;
        delay = $urandom_range(5, 1);
        send_byte(tpu_link_pkg::OP_EXECUTE);
        i = 0;
        while (!start_mlp && i < 100) begin
            @(posedge clk);
            i++;
        end
        assert (start_mlp) else report_error("start_mlp never rose");
        repeat (delay) begin
            @(posedge clk);
            assert (start_mlp == 1'b1) else report_mismatch("start_mlp", 32'd1, 32'(start_mlp));
        end
        mlp_status.state <= 4'd1;
        repeat (2) @(posedge clk);
        assert (start_mlp == 1'b0) else report_mismatch("start_mlp", 32'd0, 32'(start_mlp));
        assert (weights_ready == 1'b0)
            else report_mismatch("weights_ready", 32'd0, 32'(weights_ready));
    endtask

    task automatic load_engine_values();
        acc0_val = $urandom;
        acc1_val = $urandom;
        cnt_val  = 5'($urandom);
        @(posedge clk);
        mlp_status.acc0      <= acc0_val;
        mlp_status.acc1      <= acc1_val;
        mlp_status.cycle_cnt <= cnt_val;
        @(posedge clk);
    endtask

    task automatic run_read_acc(input tpu_link_pkg::byte_t op, input logic [31:0] exp,
                                input string name);
        tpu_link_pkg::byte_t b;
        logic [31:0]         got;
        int                  i;
        fork
            send_byte(op);
            begin
                for (i = 0; i < 4; i++) begin
                    recv_byte(b);
                    got[8*i +: 8] = b;
                end
            end
        join
        assert (got == exp) else report_mismatch(name, exp, got);
    endtask

    task automatic run_unknown_then_status();
        tpu_link_pkg::byte_t b;
        tpu_link_pkg::byte_t exp;
        send_byte(8'h7f);
        repeat (3 * 10 * BIT_CLKS) begin
            @(posedge clk);
            assert (uart_tx_line == 1'b1) else report_error("response sent for unknown opcode");
        end
        exp = {4'd1, cnt_val[3:0]};
        fork
            send_byte(tpu_link_pkg::OP_STATUS);
            recv_byte(b);
        join
        assert (b == exp) else report_mismatch("status byte", 32'(exp), 32'(b));
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the tests did not finish in time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'hafdc));
        rst          = 1'b1;
        uart_rx_line = 1'b1;
        mlp_status   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_reset_state();
        run_write_weight();
        run_write_act();
        run_execute();
        load_engine_values();
        run_read_acc(tpu_link_pkg::OP_READ_ACC0, acc0_val, "acc0");
        run_read_acc(tpu_link_pkg::OP_READ_ACC1, acc1_val, "acc1");
        run_unknown_then_status();
        repeat (10) @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* tpu_host_link.sv */
module tpu_host_link #(
    parameter int CLOCK_FREQ = 100_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      uart_rx_line,
    input  tpu_link_pkg::mlp_status_t mlp_status,
    output logic                      uart_tx_line,
    output tpu_link_pkg::wf_cmd_t     wf,
    output tpu_link_pkg::act_cmd_t    act,
    output logic                      start_mlp,
    output logic                      weights_ready
);

    tpu_link_pkg::byte_t      rx_data;
    logic                     rx_valid;
    tpu_link_pkg::byte_t      tx_data;
    logic                     tx_valid;
    logic                     tx_ready;
    logic                     wl_go;
    logic                     wl_done;
    logic                     al_go;
    logic                     al_done;
    tpu_link_pkg::payload_t   payload;
    tpu_link_pkg::resp_load_t resp;
    logic                     resp_busy;

    uart_rx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) u_uart_rx (
        .clk(clk), .rst(rst), .rx(uart_rx_line), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    uart_tx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) u_uart_tx (
        .clk(clk), .rst(rst), .tx_data(tx_data), .tx_valid(tx_valid),
        .tx(uart_tx_line), .tx_ready(tx_ready)
    );

    host_cmd_ctrl u_ctrl (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .mlp_status(mlp_status), .wl_done(wl_done), .al_done(al_done),
        .resp_busy(resp_busy), .wl_go(wl_go), .al_go(al_go), .payload(payload),
        .resp(resp), .start_mlp(start_mlp), .weights_ready(weights_ready)
    );

    weight_loader u_weight_loader (
        .clk(clk), .rst(rst), .go(wl_go), .payload(payload), .wf(wf), .done(wl_done)
    );

    act_loader u_act_loader (
        .clk(clk), .rst(rst), .go(al_go), .payload(payload), .act(act), .done(al_done)
    );

    resp_serializer u_resp (
        .clk(clk), .rst(rst), .resp(resp), .tx_ready(tx_ready),
        .tx_data(tx_data), .tx_valid(tx_valid), .busy(resp_busy)
    );

endmodule

/* tpu_link_pkg.sv */
package tpu_link_pkg;

    // Widths that carry a meaning on the host link
    typedef logic [7:0]         byte_t;
    typedef logic [15:0]        act_pair_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [3:0]         mlp_state_t;
    typedef logic [4:0]         cycle_cnt_t;
    typedef logic [31:0]        payload_t;

    // Host opcodes
    localparam byte_t OP_WRITE_WEIGHT = 8'h01;
    localparam byte_t OP_WRITE_ACT    = 8'h02;
    localparam byte_t OP_EXECUTE      = 8'h03;
    localparam byte_t OP_READ_ACC0    = 8'h04;
    localparam byte_t OP_STATUS       = 8'h05;
    localparam byte_t OP_READ_ACC1    = 8'h06;

    // Engine state code while it waits for a start
    localparam mlp_state_t MLP_IDLE = 4'd0;

    // Weight FIFO command, one push per cycle at most
    typedef struct packed {
        logic  reset;
        logic  push_col0;
        logic  push_col1;
        byte_t data;
    } wf_cmd_t;

    // Activation column beat, row 1 in the high byte
    typedef struct packed {
        logic      valid;
        act_pair_t data;
    } act_cmd_t;

    typedef struct packed {
        mlp_state_t state;
        cycle_cnt_t cycle_cnt;
        acc_t       acc0;
        acc_t       acc1;
    } mlp_status_t;

    // Response request; four_bytes low means a single status byte
    typedef struct packed {
        logic     load;
        logic     four_bytes;
        payload_t data;
    } resp_load_t;

endpackage

/* uart_rx.sv */
module uart_rx #(
    parameter int CLOCK_FREQ = 100_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx,
    output tpu_link_pkg::byte_t rx_data,
    output logic                rx_valid
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;

    // Two flops on the asynchronous line
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Half a bit in, the start bit must still be low
                    if (cnt == HALF_END) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_END) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cnt == BIT_END) begin
                        // Framing error drops the byte
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == BIT_END) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

endmodule

/* uart_tx.sv */
module uart_tx #(
    parameter int CLOCK_FREQ = 100_000_000,
    parameter int BAUD_RATE  = 115_200
) (
    input  logic                clk,
    input  logic                rst,
    input  tpu_link_pkg::byte_t tx_data,
    input  logic                tx_valid,
    output logic                tx,
    output logic                tx_ready
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;
    logic [9:0]       frame;

    assign tx_ready = (state == TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else if (state == TX_IDLE) begin
            if (tx_valid) begin
                // Start bit goes out right after the transfer edge
                state   <= TX_SEND;
                cnt     <= '0;
                bit_idx <= '0;
                tx      <= 1'b0;
            end
        end else if (cnt == BIT_END) begin
            cnt <= '0;
            if (bit_idx == 4'd9) begin
                state <= TX_IDLE;
            end else begin
                bit_idx <= bit_idx + 4'd1;
                tx      <= frame[bit_idx + 4'd1];
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Stop bit, data LSB first, start bit
    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            frame <= {1'b1, tx_data, 1'b0};
        end
    end

    // A low line is always part of a frame
    a_low_line_not_ready: assert property (@(posedge clk) disable iff (rst)
        !tx |-> !tx_ready);

endmodule

/* weight_loader.sv */
module weight_loader (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   go,
    input  tpu_link_pkg::payload_t payload,
    output tpu_link_pkg::wf_cmd_t  wf,
    output logic                   done
);

    // 0 idle, 1 to 4 one push each
    logic [2:0] step;
    logic [1:0] byte_idx;

    assign byte_idx = step[1:0] - 2'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
            wf   <= '0;
            done <= 1'b0;
        end else begin
            wf.reset     <= 1'b0;
            wf.push_col0 <= 1'b0;
            wf.push_col1 <= 1'b0;
            done         <= 1'b0;
            if (go) begin
                // Clear the FIFO pointers before the new weights
                wf.reset <= 1'b1;
                step     <= 3'd1;
            end else if (step != 3'd0) begin
                // Odd steps feed column 0, even steps column 1
                wf.data      <= payload[{byte_idx, 3'b000} +: 8];
                wf.push_col0 <= step[0];
                wf.push_col1 <= ~step[0];
                if (step == 3'd4) begin
                    done <= 1'b1;
                    step <= '0;
                end else begin
                    step <= step + 3'd1;
                end
            end
        end
    end

    a_one_column: assert property (@(posedge clk) disable iff (rst)
        !(wf.push_col0 && wf.push_col1));

endmodule
